/* hdl/cpu_pkg.sv */
/*
 * Shared definitions of the dual-issue integer core.
 * Widths, MIPS opcode and function fields, ALU operation codes,
 * the records that travel between the pipeline stages and the
 * ALU evaluation used by execute and by decode forwarding.
 */
`default_nettype none

package cpu_pkg;

    typedef logic [31:0] word_t;
    typedef logic [31:0] inst_t;
    typedef logic [4:0]  reg_addr_t;
    typedef logic [4:0]  alu_op_t;

    localparam word_t RESET_PC   = 32'hBFC0_0000;
    localparam word_t INST_BYTES = 32'd4;

    ////////////////////////////////////////
    // Major opcodes
    localparam logic [5:0] OP_SPECIAL = 6'h00;
    localparam logic [5:0] OP_ADDIU   = 6'h09;
    localparam logic [5:0] OP_SLTI    = 6'h0A;
    localparam logic [5:0] OP_ANDI    = 6'h0C;
    localparam logic [5:0] OP_ORI     = 6'h0D;
    localparam logic [5:0] OP_XORI    = 6'h0E;
    localparam logic [5:0] OP_LUI     = 6'h0F;

    // SPECIAL function field
    localparam logic [5:0] FN_ADDU = 6'h21;
    localparam logic [5:0] FN_SUBU = 6'h23;
    localparam logic [5:0] FN_AND  = 6'h24;
    localparam logic [5:0] FN_OR   = 6'h25;
    localparam logic [5:0] FN_XOR  = 6'h26;
    localparam logic [5:0] FN_NOR  = 6'h27;
    localparam logic [5:0] FN_SLT  = 6'h2A;
    localparam logic [5:0] FN_SLTU = 6'h2B;
    localparam logic [5:0] FN_SLL  = 6'h00;
    localparam logic [5:0] FN_SRL  = 6'h02;
    localparam logic [5:0] FN_SRA  = 6'h03;

    ////////////////////////////////////////
    // ALU operations
    localparam alu_op_t ALU_NOP  = 5'd0;
    localparam alu_op_t ALU_ADD  = 5'd1;
    localparam alu_op_t ALU_SUB  = 5'd2;
    localparam alu_op_t ALU_AND  = 5'd3;
    localparam alu_op_t ALU_OR   = 5'd4;
    localparam alu_op_t ALU_XOR  = 5'd5;
    localparam alu_op_t ALU_NOR  = 5'd6;
    localparam alu_op_t ALU_SLT  = 5'd7;
    localparam alu_op_t ALU_SLTU = 5'd8;
    localparam alu_op_t ALU_SLL  = 5'd9;
    localparam alu_op_t ALU_SRL  = 5'd10;
    localparam alu_op_t ALU_SRA  = 5'd11;
    localparam alu_op_t ALU_LUI  = 5'd12;

    ////////////////////////////////////////
    // Stage records
    typedef struct packed {
        logic  valid;
        word_t pc;
        inst_t inst1;
        inst_t inst2;
    } fetch_pair_t;

    typedef struct packed {
        logic      valid;
        word_t     pc;
        alu_op_t   alu_op;
        word_t     src_a;
        word_t     src_b;
        logic      we;
        reg_addr_t waddr;
    } ex_op_t;

    typedef struct packed {
        word_t     pc;
        logic      we;
        reg_addr_t waddr;
        word_t     wdata;
    } wb_t;

    function automatic word_t alu_eval(alu_op_t op, word_t a, word_t b);
        case (op)
            ALU_ADD:  return a + b;
            ALU_SUB:  return a - b;
            ALU_AND:  return a & b;
            ALU_OR:   return a | b;
            ALU_XOR:  return a ^ b;
            ALU_NOR:  return ~(a | b);
            ALU_SLT:  return {31'h0, $signed(a) < $signed(b)};
            ALU_SLTU: return {31'h0, a < b};
            ALU_SLL:  return a << b[4:0];
            ALU_SRL:  return a >> b[4:0];
            ALU_SRA:  return $signed(a) >>> b[4:0];
            ALU_LUI:  return {b[15:0], 16'h0000};
            default:  return '0;
        endcase
    endfunction

    // Write-back record of one slot
    function automatic wb_t exec_op(ex_op_t op);
        wb_t wb;
        wb.pc    = op.pc;
        wb.we    = op.valid && op.we;
        wb.waddr = op.waddr;
        wb.wdata = alu_eval(op.alu_op, op.src_a, op.src_b);
        return wb;
    endfunction

endpackage

`default_nettype wire

/* hdl/fetch_unit.sv */
/*
 * Fetch unit of the dual-issue core.
 * Presents one address per cycle and captures the returned
 * instruction pair into the fetch-to-decode register.
 * A redirect from decode reloads the pc and kills the pair in flight.
 */
`timescale 1ns/1ps
`default_nettype none

module fetch_unit (
    input  logic                 clk,
    input  logic                 rst_n_i,
    input  cpu_pkg::inst_t       inst1_i,
    input  cpu_pkg::inst_t       inst2_i,
    input  logic                 redirect_i,
    input  cpu_pkg::word_t       redirect_pc_i,
    output logic                 rreq_o,
    output cpu_pkg::word_t       raddr_o,
    output cpu_pkg::fetch_pair_t pair_o
);
    import cpu_pkg::*;

    logic  pair_valid;
    word_t pair_pc;
    inst_t pair_inst1;
    inst_t pair_inst2;

    // Program counter
    always_ff @(posedge clk or negedge rst_n_i) begin
        if (!rst_n_i) begin
            rreq_o  <= 1'b0;
            raddr_o <= RESET_PC;
        end else begin
            rreq_o <= 1'b1;
            if (redirect_i) begin
                raddr_o <= redirect_pc_i;
            end else if (rreq_o) begin
                raddr_o <= raddr_o + 2 * INST_BYTES;
            end
        end
    end

    // Pair fetched under a redirect is stale
    always_ff @(posedge clk or negedge rst_n_i) begin
        if (!rst_n_i) begin
            pair_valid <= 1'b0;
        end else begin
            pair_valid <= rreq_o && !redirect_i;
        end
    end

    always_ff @(posedge clk) begin
        pair_pc    <= raddr_o;
        pair_inst1 <= inst1_i;
        pair_inst2 <= inst2_i;
    end

    assign pair_o = '{valid: pair_valid, pc: pair_pc, inst1: pair_inst1, inst2: pair_inst2};

endmodule

`default_nettype wire

/* hdl/regfile.sv */
/*
 * General register file.
 * 32 words, four combinational read ports and two write ports.
 * Register 0 always reads as zero.
 */
`timescale 1ns/1ps
`default_nettype none

module regfile (
    input  logic               clk,
    input  logic               rst_n_i,
    input  cpu_pkg::wb_t       wb1_i,
    input  cpu_pkg::wb_t       wb2_i,
    input  cpu_pkg::reg_addr_t raddr1_i,
    input  cpu_pkg::reg_addr_t raddr2_i,
    input  cpu_pkg::reg_addr_t raddr3_i,
    input  cpu_pkg::reg_addr_t raddr4_i,
    output cpu_pkg::word_t     rdata1_o,
    output cpu_pkg::word_t     rdata2_o,
    output cpu_pkg::word_t     rdata3_o,
    output cpu_pkg::word_t     rdata4_o
);
    import cpu_pkg::*;

    word_t regs [32];

    always_ff @(posedge clk or negedge rst_n_i) begin
        if (!rst_n_i) begin
            for (int i = 0; i < 32; i++) begin
                regs[i] <= '0;
            end
        end else begin
            if (wb1_i.we) begin
                regs[wb1_i.waddr] <= wb1_i.wdata;
            end
            // Younger slot lands last on a same-register clash
            if (wb2_i.we) begin
                regs[wb2_i.waddr] <= wb2_i.wdata;
            end
        end
    end

    assign rdata1_o = (raddr1_i == '0) ? '0 : regs[raddr1_i];
    assign rdata2_o = (raddr2_i == '0) ? '0 : regs[raddr2_i];
    assign rdata3_o = (raddr3_i == '0) ? '0 : regs[raddr3_i];
    assign rdata4_o = (raddr4_i == '0) ? '0 : regs[raddr4_i];

endmodule

`default_nettype wire

/* hdl/decode_unit.sv */
/*
 * Decode stage of the dual-issue core.
 * Decodes both slots of the fetched pair, picks forwarded operands,
 * splits a pair whose second slot reads the first slot's result
 * and registers the two ALU ops for execute.
 */
`timescale 1ns/1ps
`default_nettype none

module decode_unit (
    input  logic                 clk,
    input  logic                 rst_n_i,
    input  cpu_pkg::fetch_pair_t pair_i,
    output cpu_pkg::reg_addr_t   rf_raddr1_o,
    output cpu_pkg::reg_addr_t   rf_raddr2_o,
    output cpu_pkg::reg_addr_t   rf_raddr3_o,
    output cpu_pkg::reg_addr_t   rf_raddr4_o,
    input  cpu_pkg::word_t       rf_rdata1_i,
    input  cpu_pkg::word_t       rf_rdata2_i,
    input  cpu_pkg::word_t       rf_rdata3_i,
    input  cpu_pkg::word_t       rf_rdata4_i,
    input  cpu_pkg::wb_t         ex_fwd1_i,
    input  cpu_pkg::wb_t         ex_fwd2_i,
    input  cpu_pkg::wb_t         res_fwd1_i,
    input  cpu_pkg::wb_t         res_fwd2_i,
    output logic                 redirect_o,
    output cpu_pkg::word_t       redirect_pc_o,
    output cpu_pkg::ex_op_t      ex_op1_o,
    output cpu_pkg::ex_op_t      ex_op2_o
);
    import cpu_pkg::*;

    typedef struct packed {
        alu_op_t   alu_op;
        logic      use_rs;
        logic      use_rt;
        logic      a_is_rt;
        logic      b_is_imm;
        logic      wr;
        word_t     imm;
        reg_addr_t waddr;
    } slot_dec_t;

    slot_dec_t dec1;
    slot_dec_t dec2;
    wb_t       now_wb1;
    wb_t       now_wb2;
    wb_t [5:0] fwd_src;
    word_t     rs1_val;
    word_t     rt1_val;
    word_t     rs2_val;
    word_t     rt2_val;
    word_t     pc2;
    logic      dep;
    ex_op_t    op1_d;
    ex_op_t    op2_d;

    function automatic slot_dec_t dec_slot(inst_t inst);
        slot_dec_t d;
        d          = '0;
        d.waddr    = inst[20:16];
        d.use_rs   = 1'b1;
        d.b_is_imm = 1'b1;
        d.imm      = {16'h0000, inst[15:0]};
        case (inst[31:26])
            OP_SPECIAL: begin
                d.waddr    = inst[15:11];
                d.use_rt   = 1'b1;
                d.b_is_imm = 1'b0;
                case (inst[5:0])
                    FN_ADDU: d.alu_op = ALU_ADD;
                    FN_SUBU: d.alu_op = ALU_SUB;
                    FN_AND:  d.alu_op = ALU_AND;
                    FN_OR:   d.alu_op = ALU_OR;
                    FN_XOR:  d.alu_op = ALU_XOR;
                    FN_NOR:  d.alu_op = ALU_NOR;
                    FN_SLT:  d.alu_op = ALU_SLT;
                    FN_SLTU: d.alu_op = ALU_SLTU;
                    FN_SLL:  d.alu_op = ALU_SLL;
                    FN_SRL:  d.alu_op = ALU_SRL;
                    FN_SRA:  d.alu_op = ALU_SRA;
                    default: d.alu_op = ALU_NOP;
                endcase
                // Shifts take rt as the value and sa as the amount
                if (d.alu_op inside {ALU_SLL, ALU_SRL, ALU_SRA}) begin
                    d.use_rs   = 1'b0;
                    d.a_is_rt  = 1'b1;
                    d.b_is_imm = 1'b1;
                    d.imm      = {27'h0, inst[10:6]};
                end
            end
            OP_ADDIU: begin
                d.alu_op = ALU_ADD;
                d.imm    = {{16{inst[15]}}, inst[15:0]};
            end
            OP_SLTI: begin
                d.alu_op = ALU_SLT;
                d.imm    = {{16{inst[15]}}, inst[15:0]};
            end
            OP_ANDI: d.alu_op = ALU_AND;
            OP_ORI:  d.alu_op = ALU_OR;
            OP_XORI: d.alu_op = ALU_XOR;
            OP_LUI: begin
                d.alu_op = ALU_LUI;
                d.use_rs = 1'b0;
            end
            default: d.alu_op = ALU_NOP;
        endcase
        if (d.alu_op == ALU_NOP) begin
            d.use_rs = 1'b0;
            d.use_rt = 1'b0;
        end
        d.wr = (d.alu_op != ALU_NOP) && (d.waddr != '0);
        return d;
    endfunction

    // First matching write wins, index 0 is the youngest
    function automatic word_t fwd(reg_addr_t addr, word_t rf_val, wb_t [5:0] src);
        word_t val;
        logic  hit;
        val = rf_val;
        hit = 1'b0;
        for (int i = 0; i < 6; i++) begin
            if (!hit && src[i].we && src[i].waddr == addr) begin
                val = src[i].wdata;
                hit = 1'b1;
            end
        end
        if (addr == '0) begin
            val = '0;
        end
        return val;
    endfunction

    function automatic ex_op_t build_op(logic valid, word_t pc, slot_dec_t d,
                                        word_t rs_val, word_t rt_val);
        ex_op_t op;
        op.valid  = valid;
        op.pc     = pc;
        op.alu_op = d.alu_op;
        op.src_a  = d.a_is_rt ? rt_val : rs_val;
        op.src_b  = d.b_is_imm ? d.imm : rt_val;
        op.we     = valid && d.wr;
        op.waddr  = d.waddr;
        return op;
    endfunction

    assign dec1 = dec_slot(pair_i.inst1);
    assign dec2 = dec_slot(pair_i.inst2);

    assign rf_raddr1_o = pair_i.inst1[25:21];
    assign rf_raddr2_o = pair_i.inst1[20:16];
    assign rf_raddr3_o = pair_i.inst2[25:21];
    assign rf_raddr4_o = pair_i.inst2[20:16];

    ////////////////////////////////////////
    // Operand forwarding
    // The pair now in execute has no registered result yet
    assign now_wb1 = exec_op(ex_op1_o);
    assign now_wb2 = exec_op(ex_op2_o);
    assign fwd_src = {res_fwd1_i, res_fwd2_i, ex_fwd1_i, ex_fwd2_i, now_wb1, now_wb2};

    assign rs1_val = fwd(rf_raddr1_o, rf_rdata1_i, fwd_src);
    assign rt1_val = fwd(rf_raddr2_o, rf_rdata2_i, fwd_src);
    assign rs2_val = fwd(rf_raddr3_o, rf_rdata3_i, fwd_src);
    assign rt2_val = fwd(rf_raddr4_o, rf_rdata4_i, fwd_src);

    ////////////////////////////////////////
    // Pair split and issue
    assign dep = dec1.wr && ((dec2.use_rs && rf_raddr3_o == dec1.waddr) ||
                             (dec2.use_rt && rf_raddr4_o == dec1.waddr));
    assign pc2           = pair_i.pc + INST_BYTES;
    assign redirect_o    = pair_i.valid && dep;
    assign redirect_pc_o = pc2;

    assign op1_d = build_op(pair_i.valid, pair_i.pc, dec1, rs1_val, rt1_val);
    assign op2_d = build_op(pair_i.valid && !dep, pc2, dec2, rs2_val, rt2_val);

    always_ff @(posedge clk or negedge rst_n_i) begin
        if (!rst_n_i) begin
            ex_op1_o <= '0;
            ex_op2_o <= '0;
        end else begin
            ex_op1_o <= op1_d;
            ex_op2_o <= op2_d;
        end
    end

endmodule

`default_nettype wire

/* hdl/execute_unit.sv */
/*
 * Execute stage.
 * Runs both slot ops through the ALU and registers the results,
 * which decode also sees for forwarding.
 */
`timescale 1ns/1ps
`default_nettype none

module execute_unit (
    input  logic            clk,
    input  logic            rst_n_i,
    input  cpu_pkg::ex_op_t op1_i,
    input  cpu_pkg::ex_op_t op2_i,
    output cpu_pkg::wb_t    wb1_o,
    output cpu_pkg::wb_t    wb2_o
);
    import cpu_pkg::*;

    wb_t res1;
    wb_t res2;

    // Same evaluation for both slots
    assign res1 = exec_op(op1_i);
    assign res2 = exec_op(op2_i);

    always_ff @(posedge clk or negedge rst_n_i) begin
        if (!rst_n_i) begin
            wb1_o <= '0;
            wb2_o <= '0;
        end else begin
            wb1_o <= res1;
            wb2_o <= res2;
        end
    end

endmodule

`default_nettype wire

/* hdl/result_unit.sv */
/*
 * Result stage.
 * Last pipeline register, feeding the register file writes,
 * the oldest forwarding source and the commit trace.
 */
`timescale 1ns/1ps
`default_nettype none

module result_unit (
    input  logic         clk,
    input  logic         rst_n_i,
    input  cpu_pkg::wb_t wb1_i,
    input  cpu_pkg::wb_t wb2_i,
    output cpu_pkg::wb_t rf_wb1_o,
    output cpu_pkg::wb_t rf_wb2_o
);

    always_ff @(posedge clk or negedge rst_n_i) begin
        if (!rst_n_i) begin
            rf_wb1_o <= '0;
            rf_wb2_o <= '0;
        end else begin
            rf_wb1_o <= wb1_i;
            rf_wb2_o <= wb2_i;
        end
    end

endmodule

`default_nettype wire

/* hdl/dual_issue_core.sv */
/*
 * Dual-issue MIPS integer core.
 * Fetch register, decode, execute and result stages around a
 * register file with four read and two write ports. Two commit
 * ports report every register write, slot 1 being the older one.
 */
`timescale 1ns/1ps
`default_nettype none

module dual_issue_core (
    input  logic           clk,
    input  logic           rst_n_i,
    input  cpu_pkg::inst_t inst1_i,
    input  cpu_pkg::inst_t inst2_i,
    output logic           rreq_o,
    output cpu_pkg::word_t raddr_o,
    output cpu_pkg::wb_t   commit1_o,
    output cpu_pkg::wb_t   commit2_o
);
    import cpu_pkg::*;

    fetch_pair_t id_pair;
    logic        redirect;
    word_t       redirect_pc;
    reg_addr_t   rf_raddr1;
    reg_addr_t   rf_raddr2;
    reg_addr_t   rf_raddr3;
    reg_addr_t   rf_raddr4;
    word_t       rf_rdata1;
    word_t       rf_rdata2;
    word_t       rf_rdata3;
    word_t       rf_rdata4;
    ex_op_t      ex_op1;
    ex_op_t      ex_op2;
    wb_t         ex_wb1;
    wb_t         ex_wb2;
    wb_t         rf_wb1;
    wb_t         rf_wb2;

    assign commit1_o = rf_wb1;
    assign commit2_o = rf_wb2;

    ////////////////////////////////////////
    fetch_unit u_fetch (
        .clk           (clk),
        .rst_n_i       (rst_n_i),
        .inst1_i       (inst1_i),
        .inst2_i       (inst2_i),
        .redirect_i    (redirect),
        .redirect_pc_i (redirect_pc),
        .rreq_o        (rreq_o),
        .raddr_o       (raddr_o),
        .pair_o        (id_pair)
    );

    regfile u_regfile (
        .clk      (clk),
        .rst_n_i  (rst_n_i),
        .wb1_i    (rf_wb1),
        .wb2_i    (rf_wb2),
        .raddr1_i (rf_raddr1),
        .raddr2_i (rf_raddr2),
        .raddr3_i (rf_raddr3),
        .raddr4_i (rf_raddr4),
        .rdata1_o (rf_rdata1),
        .rdata2_o (rf_rdata2),
        .rdata3_o (rf_rdata3),
        .rdata4_o (rf_rdata4)
    );

    decode_unit u_decode (
        .clk           (clk),
        .rst_n_i       (rst_n_i),
        .pair_i        (id_pair),
        .rf_raddr1_o   (rf_raddr1),
        .rf_raddr2_o   (rf_raddr2),
        .rf_raddr3_o   (rf_raddr3),
        .rf_raddr4_o   (rf_raddr4),
        .rf_rdata1_i   (rf_rdata1),
        .rf_rdata2_i   (rf_rdata2),
        .rf_rdata3_i   (rf_rdata3),
        .rf_rdata4_i   (rf_rdata4),
        .ex_fwd1_i     (ex_wb1),
        .ex_fwd2_i     (ex_wb2),
        .res_fwd1_i    (rf_wb1),
        .res_fwd2_i    (rf_wb2),
        .redirect_o    (redirect),
        .redirect_pc_o (redirect_pc),
        .ex_op1_o      (ex_op1),
        .ex_op2_o      (ex_op2)
    );

    execute_unit u_execute (
        .clk     (clk),
        .rst_n_i (rst_n_i),
        .op1_i   (ex_op1),
        .op2_i   (ex_op2),
        .wb1_o   (ex_wb1),
        .wb2_o   (ex_wb2)
    );

    result_unit u_result (
        .clk      (clk),
        .rst_n_i  (rst_n_i),
        .wb1_i    (ex_wb1),
        .wb2_i    (ex_wb2),
        .rf_wb1_o (rf_wb1),
        .rf_wb2_o (rf_wb2)
    );

endmodule

`default_nettype wire

/* tests/tb_dual_issue_core.sv */
/*
 * Testbench of the dual-issue integer core.
 * Serves instruction pairs from a memory loaded out of the stimulus
 * file and checks every committed register write against the
 * expected writes, in program order.
 */
`timescale 1ns/1ps
`default_nettype none

module tb_dual_issue_core;
    import cpu_pkg::*;

    localparam int DRAIN_CYCLES = 8;

    typedef struct packed {
        reg_addr_t waddr;
        word_t     wdata;
    } exp_write_t;

    logic  clk;
    logic  rst_n_i;
    inst_t inst1_i;
    inst_t inst2_i;
    logic  rreq_o;
    word_t raddr_o;
    wb_t   commit1_o;
    wb_t   commit2_o;

    inst_t      imem [word_t];
    exp_write_t exp_q [$];
    int         n_words;
    int         timeout_ns;
    int         value_errors;
    int         unexpected_writes;
    int         stim_errors;
    logic       stim_loaded;
    logic       first_fetch_seen;
    logic       have_last_pc;
    word_t      last_pc;

    dual_issue_core DUT (
        .clk       (clk),
        .rst_n_i   (rst_n_i),
        .inst1_i   (inst1_i),
        .inst2_i   (inst2_i),
        .rreq_o    (rreq_o),
        .raddr_o   (raddr_o),
        .commit1_o (commit1_o),
        .commit2_o (commit2_o)
    );

    always #2 clk = ~clk;

    ////////////////////////////////////////
    // Compare helpers

    task automatic check_word(input word_t got, input word_t exp, input string what);
        if (got !== exp) begin
            value_errors++;
            $display("error %0t: %s is %h, expected %h", $time, what, got, exp);
        end
    endtask

    task automatic check_reg_addr(input reg_addr_t got, input reg_addr_t exp,
                                  input string what);
        if (got !== exp) begin
            value_errors++;
            $display("error %0t: %s is %0d, expected %0d", $time, what, got, exp);
        end
    endtask

    // Commit pc must be a program word, later than the previous commit
    task automatic check_commit_pc(input word_t pc);
        if (!imem.exists(pc) || (have_last_pc && pc <= last_pc)) begin
            value_errors++;
            $display("error %0t: commit pc %h out of program order", $time, pc);
        end
        last_pc      = pc;
        have_last_pc = 1'b1;
    endtask

    task automatic take_commit(input wb_t c);
        exp_write_t e;
        if (c.we === 1'b1) begin
            if (exp_q.size() == 0) begin
                unexpected_writes++;
                $display("unexpected write to register %0d with value %h at %0t ns",
                         c.waddr, c.wdata, $time);
            end else begin
                e = exp_q.pop_front();
                check_reg_addr(c.waddr, e.waddr, "commit register");
                check_word(c.wdata, e.wdata, "commit value");
                check_commit_pc(c.pc);
            end
        end
    endtask

    function automatic inst_t read_imem(word_t addr);
        if (imem.exists(addr)) begin
            return imem[addr];
        end
        // Unfilled words are sll $0,$0,0
        return '0;
    endfunction

    task automatic load_stim();
        integer     fd;
        integer     code;
        string      tag;
        string      line;
        word_t      f_addr;
        word_t      f_word;
        integer     f_reg;
        exp_write_t e;
        fd = $fopen("tests/core_stim.txt", "r");
        if (fd == 0) begin
            stim_errors++;
            $display("cannot open stimulus file tests/core_stim.txt");
        end else begin
            while ($fscanf(fd, "%s", tag) == 1) begin
                if (tag == "I") begin
                    code = $fscanf(fd, "%h %h", f_addr, f_word);
                    if (code != 2) begin
                        stim_errors++;
                        $display("malformed program line in stimulus file");
                    end else begin
                        imem[f_addr] = f_word;
                        n_words++;
                    end
                end else if (tag == "E") begin
                    code = $fscanf(fd, "%d %h", f_reg, f_word);
                    if (code != 2) begin
                        stim_errors++;
                        $display("malformed expected write line in stimulus file");
                    end else begin
                        e.waddr = f_reg[4:0];
                        e.wdata = f_word;
                        exp_q.push_back(e);
                    end
                end else begin
                    if (tag != "#") begin
                        stim_errors++;
                        $display("unknown line tag %s in stimulus file", tag);
                    end
                    code = $fgets(line, fd);
                end
            end
            $fclose(fd);
        end
        if (exp_q.size() == 0) begin
            stim_errors++;
            $display("stimulus file holds no expected writes");
        end
    endtask

    ////////////////////////////////////////
    // Instruction memory answers after each edge
    always @(posedge clk) begin
        #1;
        inst1_i = read_imem(raddr_o);
        inst2_i = read_imem(raddr_o + INST_BYTES);
    end

    // Sample mid-cycle, away from the clock edge
    always @(negedge clk) begin
        if (!rst_n_i) begin
            if (rreq_o !== 1'b0) begin
                value_errors++;
                $display("error %0t: rreq_o high during reset", $time);
            end
            if (commit1_o.we !== 1'b0 || commit2_o.we !== 1'b0) begin
                value_errors++;
                $display("error %0t: commit write enable set during reset", $time);
            end
        end else begin
            if (rreq_o === 1'b1 && !first_fetch_seen) begin
                check_word(raddr_o, RESET_PC, "first fetch address");
                first_fetch_seen = 1'b1;
            end
            take_commit(commit1_o);
            take_commit(commit2_o);
        end
    end

    initial begin
        wait (stim_loaded === 1'b1);
        #(timeout_ns);
        $display("timeout: %0d expected writes still missing, %0d value errors",
                 exp_q.size(), value_errors);
        $display("** FAIL **");
        $finish;
    end

    initial begin
        clk               = 1'b0;
        rst_n_i           = 1'b0;
        inst1_i           = '0;
        inst2_i           = '0;
        n_words           = 0;
        value_errors      = 0;
        unexpected_writes = 0;
        stim_errors       = 0;
        stim_loaded       = 1'b0;
        first_fetch_seen  = 1'b0;
        have_last_pc      = 1'b0;
        last_pc           = '0;
        load_stim();
        timeout_ns  = 4 * n_words * 4 + 200;
        stim_loaded = 1'b1;

        repeat (2) @(posedge clk);
        #1 rst_n_i = 1'b1;

        while (exp_q.size() != 0) begin
            @(posedge clk);
        end
        // Catch stray writes behind the last expected one
        repeat (DRAIN_CYCLES) @(posedge clk);

        $display("value errors: %0d, unexpected writes: %0d, stimulus errors: %0d",
                 value_errors, unexpected_writes, stim_errors);
        if (value_errors == 0 && unexpected_writes == 0 && stim_errors == 0) begin
            $display("** PASS **");
        end else begin
            $display("** FAIL **");
        end
        $finish;
    end

endmodule

`default_nettype wire

/* tests/core_stim.txt */
# I <address hex> <instruction hex>, one program word
# E <register decimal> <value hex>, one expected write in program order
I BFC00000 3C011234
I BFC00004 34025678
I BFC00008 2403FFFF
I BFC0000C 380400F0
I BFC00010 00222821
I BFC00014 00833023
I BFC00018 00A43824
I BFC0001C 00804027
I BFC00020 00E64826
I BFC00024 0064502A
I BFC00028 0064582B
I BFC0002C 00086103
I BFC00030 00046900
I BFC00034 00037702
I BFC00038 306F8001
I BFC0003C 28700001
I BFC00040 24110064
I BFC00044 02299025
I BFC00048 02519823
I BFC0004C 24200005
I BFC00050 8C140000
I BFC00054 0013A021
I BFC00058 0014A82B
I BFC0005C 0294B027
E 1 12340000
E 2 00005678
E 3 FFFFFFFF
E 4 000000F0
E 5 12345678
E 6 000000F1
E 7 00000070
E 8 FFFFFF0F
E 9 00000081
E 10 00000001
E 11 00000000
E 12 FFFFFFF0
E 13 00000F00
E 14 0000000F
E 15 00008001
E 16 00000001
E 17 00000064
E 18 000000E5
E 19 00000081
E 20 00000081
E 21 00000001
E 22 FFFFFF7E

/* files.f */
hdl/cpu_pkg.sv
hdl/fetch_unit.sv
hdl/regfile.sv
hdl/decode_unit.sv
hdl/execute_unit.sv
hdl/result_unit.sv
hdl/dual_issue_core.sv
tests/tb_dual_issue_core.sv
